//--- hdl/permutationPkg.sv
package permutationPkg;

    // Word layout shared by the datapath and the host side
    localparam int wordWidth   = 128;
    localparam int resultWidth = 64;

    // Bot result fields, sum in the low bits and match count above it
    localparam int sumWidth    = 48;
    localparam int countWidth  = 13;

    // Source of each queued result, in issue order
    typedef enum logic [0:0] {
        originTop = 1'b0,
        originBot = 1'b1
    } resultOrigin_t;

    // Input controller states
    typedef enum logic [1:0] {
        // Ready held low after reset
        stInit    = 2'd0,
        stRun     = 2'd1,
        // Top waiting in the holding register for the pipeline to empty
        stDrain   = 2'd2,
        stLoadTop = 2'd3
    } ctrlState_t;

endpackage

//--- hdl/resultOriginFifo.sv
`timescale 1ns/1ps

module resultOriginFifo #(
    parameter int WIDTH = 1,
    parameter int DEPTH_LOG2 = 6
) (
    input  logic clk,
    input  logic resetn,
    input  logic writeEnable,
    input  logic [WIDTH-1:0] dataIn,
    input  logic readEnable,
    output logic [WIDTH-1:0] dataOut,
    output logic empty,
    output logic full,
    output logic [DEPTH_LOG2:0] freeCount
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0] storage [DEPTH];
    logic [DEPTH_LOG2-1:0] readPtr;
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2:0] used;
    logic doRead;
    logic doWrite;

    assign doRead = readEnable && !empty;
    // A full queue still takes a word when the head leaves on the same edge
    assign doWrite = writeEnable && (!full || doRead);

    assign empty = (used == '0);
    assign full = (used == (DEPTH_LOG2 + 1)'(DEPTH));
    assign freeCount = (DEPTH_LOG2 + 1)'(DEPTH) - used;

    // Show-ahead head word
    assign dataOut = storage[readPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            storage[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            readPtr <= '0;
            writePtr <= '0;
            used <= '0;
        end else begin
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: used <= used + 1'b1;
                2'b01: used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

endmodule

//--- hdl/permutationController.sv
`timescale 1ns/1ps

module permutationController #(
    parameter int INIT_CYCLES = 8
) (
    input  logic clk,
    input  logic resetn,
    input  logic ivalid,
    input  logic startNewTop,
    input  logic [63:0] botLower,
    input  logic [63:0] botUpper,
    input  logic pipelineEmpty,
    input  logic resultSpace,
    input  logic originFull,
    output logic oready,
    output logic writeBot,
    output logic [permutationPkg::wordWidth-1:0] botWord,
    output logic [permutationPkg::wordWidth-1:0] topWord,
    output logic pushOrigin,
    output permutationPkg::resultOrigin_t originIn
);
    import permutationPkg::*;

    localparam int INIT_WIDTH = $clog2(INIT_CYCLES + 2);

    ctrlState_t state;
    ctrlState_t nextState;
    logic [INIT_WIDTH-1:0] initCount;
    logic [wordWidth-1:0] heldWord;
    logic heldValid;
    logic heldIsTop;
    logic [wordWidth-1:0] topReg;
    logic loadTop;
    logic heldIssued;
    logic accept;

    // Bots go straight out of the holding register when the buffers have room
    assign writeBot = (state == stRun) && heldValid && !heldIsTop && resultSpace && !originFull;
    assign loadTop = (state == stLoadTop);
    assign heldIssued = writeBot || loadTop;

    // Holding register frees up on the same edge it is issued
    assign oready = (state != stInit) && (!heldValid || heldIssued) && resultSpace && !originFull;
    assign accept = ivalid && oready;

    assign pushOrigin = heldIssued;
    assign originIn = loadTop ? originTop : originBot;
    assign botWord = heldWord;
    assign topWord = topReg;

    always_comb begin
        nextState = state;
        case (state)
            stInit: begin
                if (initCount <= INIT_WIDTH'(1)) begin
                    nextState = stRun;
                end
            end
            stRun: begin
                if (heldValid && heldIsTop) begin
                    nextState = stDrain;
                end
            end
            stDrain: begin
                // Origin slot checked here, the push happens in stLoadTop
                if (pipelineEmpty && !originFull) begin
                    nextState = stLoadTop;
                end
            end
            stLoadTop: begin
                nextState = stRun;
            end
            default: begin
                nextState = stInit;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= stInit;
            initCount <= INIT_WIDTH'(INIT_CYCLES);
        end else begin
            state <= nextState;
            if (state == stInit && initCount != '0) begin
                initCount <= initCount - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            heldValid <= 1'b0;
            heldIsTop <= 1'b0;
        end else if (accept) begin
            heldValid <= 1'b1;
            heldIsTop <= startNewTop;
        end else if (heldIssued) begin
            heldValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldWord <= {botUpper, botLower};
        end
    end

    // Bots before the first top compare against an all-zero top
    always_ff @(posedge clk) begin
        if (!resetn) begin
            topReg <= '0;
        end else if (loadTop) begin
            topReg <= heldWord;
        end
    end

endmodule

//--- hdl/permutationPipeline.sv
`timescale 1ns/1ps

module permutationPipeline #(
    parameter int RESULT_DEPTH_LOG2 = 3
) (
    input  logic clk,
    input  logic resetn,
    input  logic writeBot,
    input  logic [permutationPkg::wordWidth-1:0] botWord,
    input  logic [permutationPkg::wordWidth-1:0] topWord,
    input  logic grabBot,
    output logic resultsAvailable,
    output logic [permutationPkg::resultWidth-1:0] result,
    output logic pipelineEmpty,
    output logic resultSpace,
    output logic [2:0] activityMeasure
);
    import permutationPkg::*;

    localparam int ROTATIONS = 4;
    localparam int ROT_STEP = wordWidth / ROTATIONS;
    localparam int POP_WIDTH = $clog2(wordWidth + 1);
    localparam int SUM_RAW = POP_WIDTH + 2;
    // Four stages in flight plus the bot being issued
    localparam int SPACE_NEEDED = 5;

    function automatic logic [POP_WIDTH-1:0] popCount(input logic [wordWidth-1:0] value);
        logic [POP_WIDTH-1:0] total;
        total = '0;
        for (int i = 0; i < wordWidth; i++) begin
            total = total + POP_WIDTH'(value[i]);
        end
        return total;
    endfunction

    function automatic logic [wordWidth-1:0] rotateLeft(input logic [wordWidth-1:0] value,
                                                        input int shift);
        logic [2*wordWidth-1:0] doubled;
        doubled = {value, value};
        return doubled[2*wordWidth-1-shift -: wordWidth];
    endfunction

    logic [3:0] stageValid;
    logic [wordWidth-1:0] s1Rot [ROTATIONS];
    logic [wordWidth-1:0] s2And [ROTATIONS];
    logic [ROTATIONS-1:0] s2Subset;
    logic [POP_WIDTH-1:0] s3Pop [ROTATIONS];
    logic [ROTATIONS-1:0] s3Subset;
    logic [resultWidth-1:0] s4Result;
    logic [SUM_RAW-1:0] popTotal;
    logic [2:0] matchTotal;
    logic bufferEmpty;
    logic [RESULT_DEPTH_LOG2:0] bufferFree;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[2:0], writeBot};
        end
    end

    always_ff @(posedge clk) begin
        // Stage 1 forms the rotations
        if (writeBot) begin
            for (int r = 0; r < ROTATIONS; r++) begin
                s1Rot[r] <= rotateLeft(botWord, r * ROT_STEP);
            end
        end
        // Stage 2 masks with the top, subset when nothing falls outside it
        if (stageValid[0]) begin
            for (int r = 0; r < ROTATIONS; r++) begin
                s2And[r] <= s1Rot[r] & topWord;
                s2Subset[r] <= ((s1Rot[r] & ~topWord) == '0);
            end
        end
        if (stageValid[1]) begin
            for (int r = 0; r < ROTATIONS; r++) begin
                s3Pop[r] <= popCount(s2And[r]);
            end
            s3Subset <= s2Subset;
        end
        if (stageValid[2]) begin
            s4Result <= {{(resultWidth - sumWidth - countWidth){1'b0}},
                         countWidth'(matchTotal), sumWidth'(popTotal)};
        end
    end

    always_comb begin
        popTotal = '0;
        matchTotal = '0;
        for (int r = 0; r < ROTATIONS; r++) begin
            popTotal = popTotal + SUM_RAW'(s3Pop[r]);
            matchTotal = matchTotal + 3'(s3Subset[r]);
        end
    end

    always_comb begin
        activityMeasure = '0;
        for (int s = 0; s < 4; s++) begin
            activityMeasure = activityMeasure + 3'(stageValid[s]);
        end
    end

    // Stage 4 output lands here four cycles after writeBot
    resultOriginFifo #(
        .WIDTH(resultWidth),
        .DEPTH_LOG2(RESULT_DEPTH_LOG2)
    ) resultBuffer (
        .clk(clk),
        .resetn(resetn),
        .writeEnable(stageValid[3]),
        .dataIn(s4Result),
        .readEnable(grabBot),
        .dataOut(result),
        .empty(bufferEmpty),
        .full(),
        .freeCount(bufferFree)
    );

    assign resultsAvailable = !bufferEmpty;
    assign pipelineEmpty = (stageValid == '0);
    assign resultSpace = (bufferFree >= (RESULT_DEPTH_LOG2 + 1)'(SPACE_NEEDED));

endmodule

//--- hdl/activityProfiler.sv
`timescale 1ns/1ps

module activityProfiler (
    input  logic clk,
    input  logic resetn,
    input  logic [2:0] activityMeasure,
    input  logic grabProfile,
    output logic [permutationPkg::resultWidth-1:0] profileWord
);
    import permutationPkg::*;

    localparam int HALF = resultWidth / 2;

    logic [HALF-1:0] clockCount;
    logic [HALF-1:0] activityCount;
    logic [HALF:0] activitySum;

    // Extra bit catches the carry for saturation
    assign activitySum = {1'b0, activityCount} + (HALF + 1)'(activityMeasure);

    // Occupancy is activity / (4 * clocks)
    assign profileWord = {activityCount, clockCount};

    always_ff @(posedge clk) begin
        if (!resetn || grabProfile) begin
            clockCount <= '0;
            activityCount <= '0;
        end else begin
            if (clockCount != '1) begin
                clockCount <= clockCount + 1'b1;
            end
            if (activitySum[HALF]) begin
                activityCount <= '1;
            end else begin
                activityCount <= activitySum[HALF-1:0];
            end
        end
    end

endmodule

//--- hdl/permutationTop.sv
`timescale 1ns/1ps

module permutationTop #(
    parameter int INIT_CYCLES = 8,
    parameter int ORIGIN_DEPTH_LOG2 = 6,
    parameter int RESULT_DEPTH_LOG2 = 3
) (
    input  logic clk,
    input  logic resetn,
    input  logic ivalid,
    input  logic startNewTop,
    input  logic [63:0] botLower,
    input  logic [63:0] botUpper,
    input  logic iready,
    output logic oready,
    output logic ovalid,
    output logic [permutationPkg::resultWidth-1:0] resultData
);
    import permutationPkg::*;

    localparam int ORIGIN_WIDTH = $bits(resultOrigin_t);

    logic writeBot;
    logic [wordWidth-1:0] botWord;
    logic [wordWidth-1:0] topWord;
    logic pushOrigin;
    resultOrigin_t originIn;
    logic pipelineEmpty;
    logic resultSpace;
    logic originFull;
    logic originEmpty;
    logic [ORIGIN_WIDTH-1:0] originHeadBits;
    resultOrigin_t headOrigin;
    logic botAvailable;
    logic [resultWidth-1:0] botResult;
    logic [resultWidth-1:0] profileWord;
    logic [2:0] activityMeasure;
    logic transfer;
    logic grabBot;
    logic grabProfile;

    permutationController #(
        .INIT_CYCLES(INIT_CYCLES)
    ) controller (
        .clk(clk),
        .resetn(resetn),
        .ivalid(ivalid),
        .startNewTop(startNewTop),
        .botLower(botLower),
        .botUpper(botUpper),
        .pipelineEmpty(pipelineEmpty),
        .resultSpace(resultSpace),
        .originFull(originFull),
        .oready(oready),
        .writeBot(writeBot),
        .botWord(botWord),
        .topWord(topWord),
        .pushOrigin(pushOrigin),
        .originIn(originIn)
    );

    // One entry per issued word keeps the output in input order
    resultOriginFifo #(
        .WIDTH(ORIGIN_WIDTH),
        .DEPTH_LOG2(ORIGIN_DEPTH_LOG2)
    ) originQueue (
        .clk(clk),
        .resetn(resetn),
        .writeEnable(pushOrigin),
        .dataIn(originIn),
        .readEnable(transfer),
        .dataOut(originHeadBits),
        .empty(originEmpty),
        .full(originFull),
        .freeCount()
    );

    permutationPipeline #(
        .RESULT_DEPTH_LOG2(RESULT_DEPTH_LOG2)
    ) pipeline (
        .clk(clk),
        .resetn(resetn),
        .writeBot(writeBot),
        .botWord(botWord),
        .topWord(topWord),
        .grabBot(grabBot),
        .resultsAvailable(botAvailable),
        .result(botResult),
        .pipelineEmpty(pipelineEmpty),
        .resultSpace(resultSpace),
        .activityMeasure(activityMeasure)
    );

    activityProfiler profiler (
        .clk(clk),
        .resetn(resetn),
        .activityMeasure(activityMeasure),
        .grabProfile(grabProfile),
        .profileWord(profileWord)
    );

    assign headOrigin = resultOrigin_t'(originHeadBits);

    // Occupancy record is always ready, a bot waits for its result
    assign ovalid = !originEmpty && (headOrigin == originTop || botAvailable);
    assign resultData = (headOrigin == originTop) ? profileWord : botResult;

    assign transfer = ovalid && iready;
    assign grabBot = transfer && (headOrigin == originBot);
    assign grabProfile = transfer && (headOrigin == originTop);

endmodule

//--- verification/permutationTop_asserts.sv
`timescale 1ns/1ps

module permutationTop_asserts (
    input logic clk,
    input logic resetn,
    input logic ovalid,
    input logic oready,
    input logic iready,
    input logic [permutationPkg::resultWidth-1:0] resultData,
    input permutationPkg::resultOrigin_t headOrigin
);
    import permutationPkg::*;

    // Registers are settled after the first reset edge
    resetQuiet: assert property (
        @(posedge clk) (!resetn ##1 !resetn) |-> (!ovalid && !oready)
    ) else $error("ovalid or oready high during reset");

    // A stalled bot result must hold, the occupancy record keeps counting
    stalledBotStable: assert property (
        @(posedge clk) disable iff (!resetn)
        (ovalid && !iready && headOrigin == originBot) |=> $stable(resultData)
    ) else $error("bot result changed while stalled");

    botTopBitsZero: assert property (
        @(posedge clk) disable iff (!resetn)
        (ovalid && headOrigin == originBot) |-> (resultData[63:61] == 3'b000)
    ) else $error("bot result bits 63 to 61 not zero");

endmodule

//--- verification/permutationTb.sv
`timescale 1ns/1ps

module permutationTb;
    import permutationPkg::*;

    localparam int INIT_CYCLES = 8;
    localparam int ENTRY_WIDTH = 4 + wordWidth + resultWidth;
    localparam int MAX_ENTRIES = 64;
    localparam int TIMEOUT_CYCLES = 2000;
    // A top drain alone holds oready low for at most five cycles
    localparam int DRAIN_WAIT_MAX = 8;

    // Kind nibble of a data file entry
    localparam logic [3:0] KIND_TOP = 4'h1;
    localparam logic [3:0] KIND_BURST_BOT = 4'h2;
    localparam logic [3:0] KIND_BURST_TOP = 4'h3;
    localparam logic [3:0] KIND_END = 4'hf;

    logic clk;
    logic resetn;
    logic ivalid;
    logic startNewTop;
    logic [63:0] botLower;
    logic [63:0] botUpper;
    logic iready;
    logic oready;
    logic ovalid;
    logic [resultWidth-1:0] resultData;

    logic [ENTRY_WIDTH-1:0] testData [MAX_ENTRIES];
    logic [3:0] expectKind [$];
    logic [resultWidth-1:0] expectValue [$];
    logic [31:0] cyclesSinceReset = '0;
    integer seed = 32'h8b95_bc20;
    int errorCount = 0;
    int checkCount = 0;
    int acceptedCount = 0;
    int receivedCount = 0;
    int lowLeft = 0;
    bit burstMode = 1'b0;
    bit stretchForced = 1'b0;
    bit sawBackpressure = 1'b0;
    bit firstRecord = 1'b1;
    bit timedOut = 1'b0;

    permutationTop #(
        .INIT_CYCLES(INIT_CYCLES)
    ) DUT (
        .clk(clk),
        .resetn(resetn),
        .ivalid(ivalid),
        .startNewTop(startNewTop),
        .botLower(botLower),
        .botUpper(botUpper),
        .iready(iready),
        .oready(oready),
        .ovalid(ovalid),
        .resultData(resultData)
    );

    bind permutationTop permutationTop_asserts asserts (
        .clk(clk),
        .resetn(resetn),
        .ovalid(ovalid),
        .oready(oready),
        .iready(iready),
        .resultData(resultData),
        .headOrigin(headOrigin)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Clocks since reset, the bound for the first occupancy record
    always @(posedge clk) begin
        if (resetn) begin
            cyclesSinceReset <= cyclesSinceReset + 1;
        end
    end

    task automatic sendWord(input logic [ENTRY_WIDTH-1:0] entry);
        logic [3:0] kind;
        int waitCycles;
        kind = entry[ENTRY_WIDTH-1 -: 4];
        waitCycles = 0;
        ivalid = 1'b1;
        startNewTop = (kind == KIND_TOP) || (kind == KIND_BURST_TOP);
        botUpper = entry[resultWidth + 64 +: 64];
        botLower = entry[resultWidth +: 64];
        while (!oready && !timedOut) begin
            waitCycles++;
            if (waitCycles > DRAIN_WAIT_MAX) begin
                sawBackpressure = 1'b1;
            end
            if (waitCycles > TIMEOUT_CYCLES) begin
                timedOut = 1'b1;
                errorCount++;
                $display("Timeout: input word %0d was never accepted", acceptedCount);
            end else begin
                @(negedge clk);
            end
        end
        if (!timedOut) begin
            // oready is registered state, so this word goes in at the next edge
            expectKind.push_back(kind);
            expectValue.push_back(entry[resultWidth-1:0]);
            acceptedCount++;
            @(negedge clk);
        end
    endtask

    task automatic waitForResults();
        int waitCycles;
        waitCycles = 0;
        while (receivedCount < acceptedCount && !timedOut) begin
            waitCycles++;
            if (waitCycles > TIMEOUT_CYCLES) begin
                timedOut = 1'b1;
                errorCount++;
                $display("Timeout: %0d results never came out", acceptedCount - receivedCount);
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic checkRecord(input logic [3:0] kind, input logic [resultWidth-1:0] word);
        logic [31:0] lowerHalf;
        logic [31:0] upperHalf;
        lowerHalf = word[31:0];
        upperHalf = word[63:32];
        checkCount++;
        assert (lowerHalf != 32'h0) else begin
            errorCount++;
            $display("[ERROR] resultData record clock count: got 0x%08h expected nonzero",
                     lowerHalf);
        end
        // At most four busy stages per clock
        checkCount++;
        assert ({2'b00, upperHalf} <= {lowerHalf, 2'b00}) else begin
            errorCount++;
            $display("[ERROR] resultData record activity: got 0x%08h limit 0x%09h",
                     upperHalf, {lowerHalf, 2'b00});
        end
        if (firstRecord) begin
            checkCount++;
            assert (lowerHalf <= cyclesSinceReset) else begin
                errorCount++;
                $display("[ERROR] resultData first record clocks: got 0x%08h max 0x%08h",
                         lowerHalf, cyclesSinceReset);
            end
            firstRecord = 1'b0;
        end
        if (kind == KIND_BURST_TOP) begin
            checkCount++;
            assert (upperHalf != 32'h0) else begin
                errorCount++;
                $display("[ERROR] resultData burst record activity: got 0x%08h expected nonzero",
                         upperHalf);
            end
        end
    endtask

    // Output side: iready and result checks, both decided at the falling edge
    initial begin
        logic [3:0] kind;
        logic [resultWidth-1:0] expected;
        int r;
        iready = 1'b0;
        forever begin
            @(negedge clk);
            if (!resetn) begin
                iready = 1'b0;
            end else if (burstMode) begin
                iready = 1'b1;
            end else if (lowLeft > 0) begin
                iready = 1'b0;
                lowLeft--;
            end else begin
                r = $random(seed);
                if (r[3:0] == 4'h0) begin
                    lowLeft = 8 + int'(r[8:4]);
                    iready = 1'b0;
                end else begin
                    iready = r[5] | r[6];
                end
            end
            if (ovalid && iready) begin
                if (expectKind.size() == 0) begin
                    errorCount++;
                    $display("A result came out with no word outstanding");
                end else begin
                    kind = expectKind.pop_front();
                    expected = expectValue.pop_front();
                    if (kind == KIND_TOP || kind == KIND_BURST_TOP) begin
                        checkRecord(kind, resultData);
                    end else begin
                        checkCount++;
                        assert (resultData === expected) else begin
                            errorCount++;
                            $display("[ERROR] resultData word %0d: got 0x%016h expected 0x%016h",
                                     receivedCount, resultData, expected);
                        end
                        // One long stall early on to fill the result buffer
                        if (!stretchForced) begin
                            stretchForced = 1'b1;
                            lowLeft = 30;
                        end
                    end
                end
                receivedCount++;
            end
        end
    end

    initial begin
        logic [ENTRY_WIDTH-1:0] entry;
        logic [3:0] kind;
        int idx;
        int lowCycles;
        resetn = 1'b0;
        ivalid = 1'b0;
        startNewTop = 1'b0;
        botLower = '0;
        botUpper = '0;
        for (int i = 0; i < MAX_ENTRIES; i++) begin
            testData[i] = {KIND_END, {(ENTRY_WIDTH - 4){1'b0}}};
        end
        $readmemh("verification/permutationTestdata.hex", testData);

        repeat (16) begin
            @(negedge clk);
            checkCount++;
            assert (!oready && !ovalid) else begin
                errorCount++;
                $display("[ERROR] oready/ovalid during reset: got 0x%0h/0x%0h expected 0x0/0x0",
                         oready, ovalid);
            end
        end
        resetn = 1'b1;

        lowCycles = 0;
        while (!oready && !timedOut) begin
            checkCount++;
            assert (!ovalid) else begin
                errorCount++;
                $display("[ERROR] ovalid before any input: got 0x%0h expected 0x0", ovalid);
            end
            lowCycles++;
            if (lowCycles > TIMEOUT_CYCLES) begin
                timedOut = 1'b1;
                errorCount++;
                $display("Timeout: oready never rose after reset");
            end else begin
                @(negedge clk);
            end
        end
        checkCount++;
        assert (lowCycles >= INIT_CYCLES) else begin
            errorCount++;
            $display("[ERROR] oready low cycles after reset: got 0x%0h expected >= 0x%0h",
                     lowCycles, INIT_CYCLES);
        end

        idx = 0;
        while (!timedOut && idx < MAX_ENTRIES) begin
            entry = testData[idx];
            kind = entry[ENTRY_WIDTH-1 -: 4];
            if (kind == KIND_END) begin
                break;
            end
            if (kind == KIND_BURST_BOT) begin
                // Profiler starts clean and iready stays high for the burst
                ivalid = 1'b0;
                burstMode = 1'b1;
                waitForResults();
            end
            if (!timedOut) begin
                sendWord(entry);
            end
            idx++;
        end
        ivalid = 1'b0;
        startNewTop = 1'b0;
        burstMode = 1'b1;
        waitForResults();

        // Idle a little so a stray extra result would show up
        if (!timedOut) begin
            repeat (20) @(negedge clk);
        end
        checkCount++;
        assert (sawBackpressure) else begin
            errorCount++;
            $display("oready never held off a word for longer than a top drain");
        end

        $display("Checks: %0d, errors: %0d, words accepted: %0d, results received: %0d",
                 checkCount, errorCount, acceptedCount, receivedCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verification/permutationTestdata.hex
// kind_word_expected: kind 0 bot, 1 top, 2 first burst bot, 3 top after burst, f end
// word is botUpper:botLower as four 32-bit lanes, expected is zero for tops
0_00000000_00000000_00000000_00000000_0004000000000000
0_ffffffff_ffffffff_ffffffff_ffffffff_0000000000000000
1_ffffffff_ffffffff_ffffffff_ffffffff_0000000000000000
0_00000000_00000000_00000000_00000001_0004000000000004
0_ffffffff_ffffffff_ffffffff_ffffffff_0004000000000200
0_0000000f_000000ff_00000000_00000001_0004000000000034
1_00000000_00000000_00000000_ffffffff_0000000000000000
0_00000000_00000000_00000000_00000003_0001000000000002
0_12345678_00000000_00000000_00000000_000100000000000d
0_00000001_00000001_00000000_00000000_0000000000000002
0_00000000_00000000_00000000_00000000_0004000000000000
1_0000ffff_0000ffff_0000ffff_0000ffff_0000000000000000
0_0000ffff_0000ffff_0000ffff_0000ffff_0004000000000100
0_00010001_00000000_00000000_00000000_0000000000000004
0_00000000_00000000_00000000_000000ff_0004000000000020
1_ffffffff_ffffffff_ffffffff_ffffffff_0000000000000000
2_00000000_00000000_00000000_00000001_0004000000000004
0_00000000_00000000_00000000_00000003_0004000000000008
0_00000000_00000000_00000000_00000007_000400000000000c
0_00000000_00000000_00000000_0000000f_0004000000000010
0_00000000_00000000_00000000_000000ff_0004000000000020
0_00000000_00000000_00000000_0000ffff_0004000000000040
0_00000000_00000000_00000000_ffffffff_0004000000000080
0_00000000_00000000_ffffffff_ffffffff_0004000000000100
3_00000000_00000000_00000000_00000000_0000000000000000
0_00000000_00000000_00000000_00000000_0004000000000000
f_00000000_00000000_00000000_00000000_0000000000000000

//--- verilog.f
hdl/permutationPkg.sv
hdl/resultOriginFifo.sv
hdl/permutationController.sv
hdl/permutationPipeline.sv
hdl/activityProfiler.sv
hdl/permutationTop.sv
verification/permutationTop_asserts.sv
verification/permutationTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= permutationTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Test completed successfully
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
